//--- Makefile
# Verilator build and run of the heap array unit testbench

VERILATOR ?= verilator
TOP       ?= heapArrayUnitTb
RTL_TOP   ?= heapArrayUnit
FILE_LIST ?= all.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --timing --assert
PASS_TEXT ?= All tests passed

SOURCES := $(wildcard hdl/*.sv hdl/*.svh dv/*.sv)
BINARY  := $(BUILD_DIR)/V$(TOP)

.PHONY: all run lint clean

all: run

$(BINARY): $(FILE_LIST) $(SOURCES)
	$(VERILATOR) --binary $(VFLAGS) -f $(FILE_LIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

# Fails unless the pass message shows up in the output
run: $(BINARY)
	@out="$$($(BINARY))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_TEXT)"

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILE_LIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(BUILD_DIR)

//--- all.f
+incdir+hdl
hdl/heapPkg.sv
hdl/arrayStore.sv
hdl/sizeTable.sv
hdl/arrayAllocator.sv
hdl/heapControl.sv
hdl/heapArrayUnit.sv
dv/heapArrayUnit_chk.sv
dv/heapArrayUnitTb.sv

//--- dv/heapArrayUnitTb.sv
//--------------------
// Heap array unit testbench
// Directed tests of allocation, access, stack and arithmetic commands
//--------------------
`timescale 1ns/10ps

module heapArrayUnitTb;
  import heapPkg::*;

  localparam int CycleLimit = 2000;   // Far beyond the full test run

  logic   clock;
  logic   resetN;
  logic   request;
  actionE action;
  arrayT  array;
  indexT  index;
  dataT   dataIn;
  dataT   dataOut;
  errorE  error;
  logic   done;

  int   errorCount = 0;
  int   checkCount = 0;
  int   cycleCount = 0;
  dataT modelOut   = '0;   // Expected dataOut register

  heapArrayUnit u_dut (
    .clock   (clock),
    .resetN  (resetN),
    .request (request),
    .action  (action),
    .array   (array),
    .index   (index),
    .dataIn  (dataIn),
    .dataOut (dataOut),
    .error   (error),
    .done    (done)
  );

  bind heapArrayUnit heapArrayUnit_chk u_chk (
    .clock   (clock),
    .resetN  (resetN),
    .request (request),
    .done    (done),
    .error   (error)
  );

  initial begin
    clock = 1'b0;
    forever #50 clock = ~clock;
  end

  initial begin
    while (cycleCount < CycleLimit) begin
      @(posedge clock);
      cycleCount++;
    end
    $display("Timeout after %0d cycles, the tests did not finish", CycleLimit);
    $display("Some tests failed");
    $finish;
  end

  //--------------------
  // Helpers
  //--------------------
  task automatic checkValue(input int actual, input int expected, input string what);
    checkCount++;
    if (actual != expected) begin
      errorCount++;
      $display("[ERROR] %0t: %s, got %0d, expected %0d", $time, what, actual, expected);
    end
  endtask

  task automatic doCommand(input actionE act, input arrayT arr, input indexT idx,
                           input dataT data, output dataT result, output errorE err);
    int waited;
    @(posedge clock);
    #10;
    request = 1'b1;   // One-cycle strobe
    action  = act;
    array   = arr;
    index   = idx;
    dataIn  = data;
    @(posedge clock);
    #10;
    request = 1'b0;
    waited  = 0;
    while (!done && waited < 4) begin
      @(posedge clock);
      #10;
      waited++;
    end
    if (!done) begin
      errorCount++;
      $display("Command %s never raised done", act.name());
    end
    result = dataOut;
    err    = error;
  endtask

  // Failed commands, Reset and Free leave dataOut as it was
  task automatic expectCommand(input actionE act, input arrayT arr, input indexT idx,
                               input dataT data, input errorE expErr, input dataT expData,
                               input string what, output dataT result);
    errorE err;
    doCommand(act, arr, idx, data, result, err);
    if (expErr == errNone && act != actReset && act != actFree) begin
      modelOut = expData;
    end
    checkValue(int'(err), int'(expErr), {what, " error code"});
    checkValue(int'(result), int'(modelOut), {what, " data out"});
  endtask

  task automatic reportTest(input string name, input int startErrors);
    $display("Test %s finished with %0d errors", name, errorCount - startErrors);
  endtask

  //--------------------
  // Tests
  //--------------------
  task automatic testAllocation();
    int   startErrors;
    dataT scratch;
    startErrors = errorCount;
    expectCommand(actReset, 0, 0, 0, errNone, 0, "Reset", scratch);
    for (int a = 0; a < 4; a++) begin
      expectCommand(actAlloc, 0, 0, 0, errNone, dataT'(a), "Alloc in order", scratch);
    end
    expectCommand(actAlloc, 0, 0, 0, errOutOfMemory, 0, "Alloc when exhausted", scratch);
    expectCommand(actFree, 2, 0, 0, errNone, 0, "Free 2", scratch);
    expectCommand(actFree, 1, 0, 0, errNone, 0, "Free 1", scratch);
    expectCommand(actAlloc, 0, 0, 0, errNone, 12'd1, "Alloc last freed", scratch);   // LIFO
    expectCommand(actAlloc, 0, 0, 0, errNone, 12'd2, "Alloc earlier freed", scratch);
    reportTest("allocation", startErrors);
  endtask

  task automatic testReferenceProgram();
    int   startErrors;
    dataT first;
    dataT second;
    dataT scratch;
    startErrors = errorCount;
    expectCommand(actReset, 0, 0, 0, errNone, 0, "Reset", scratch);
    expectCommand(actAlloc, 0, 0, 0, errNone, 12'd0, "Alloc first", scratch);
    expectCommand(actAlloc, 0, 0, 0, errNone, 12'd1, "Alloc second", scratch);
    expectCommand(actWrite, 1, 0, 12'd11, errNone, 12'd11, "Write 11", scratch);
    expectCommand(actWrite, 1, 1, 12'd22, errNone, 12'd22, "Write 22", scratch);
    expectCommand(actRead, 1, 0, 0, errNone, 12'd11, "Read index 0", first);
    expectCommand(actRead, 1, 1, 0, errNone, 12'd22, "Read index 1", second);
    expectCommand(actWrite, 1, 2, first + second, errNone, 12'd33, "Write sum", scratch);
    expectCommand(actRead, 1, 2, 0, errNone, 12'd33, "Read sum", scratch);
    expectCommand(actSize, 1, 0, 0, errNone, 12'd3, "Size after writes", scratch);
    reportTest("reference program", startErrors);
  endtask

  task automatic testPushPop();
    int   startErrors;
    dataT values [4];
    dataT scratch;
    startErrors = errorCount;
    expectCommand(actReset, 0, 0, 0, errNone, 0, "Reset", scratch);
    expectCommand(actAlloc, 0, 0, 0, errNone, 12'd0, "Alloc", scratch);
    for (int i = 0; i < 4; i++) begin
      values[i] = dataT'($urandom);
      expectCommand(actPush, 0, 0, values[i], errNone, values[i], "Push", scratch);
      expectCommand(actSize, 0, 0, 0, errNone, dataT'(i + 1), "Size after push", scratch);
    end
    expectCommand(actPush, 0, 0, 12'h5a5, errFull, 0, "Push on full array", scratch);
    for (int i = 3; i >= 0; i--) begin
      expectCommand(actPop, 0, 0, 0, errNone, values[i], "Pop", scratch);   // Reverse order
      expectCommand(actSize, 0, 0, 0, errNone, dataT'(i), "Size after pop", scratch);
    end
    expectCommand(actPop, 0, 0, 0, errEmpty, 0, "Pop on empty array", scratch);
    reportTest("push and pop", startErrors);
  endtask

  task automatic testAccessErrors();
    int   startErrors;
    dataT scratch;
    startErrors = errorCount;
    expectCommand(actReset, 0, 0, 0, errNone, 0, "Reset", scratch);
    expectCommand(actAlloc, 0, 0, 0, errNone, 12'd0, "Alloc first", scratch);
    expectCommand(actAlloc, 0, 0, 0, errNone, 12'd1, "Alloc second", scratch);
    expectCommand(actWrite, 0, 0, 12'h123, errNone, 12'h123, "Write marker", scratch);
    expectCommand(actRead, 0, 1, 0, errOutOfBounds, 0, "Read past size", scratch);
    expectCommand(actRead, 3, 0, 0, errNotAllocated, 0, "Read unallocated", scratch);
    expectCommand(actWrite, 2, 0, 12'h7, errNotAllocated, 0, "Write unallocated", scratch);
    expectCommand(actFree, 1, 0, 0, errNone, 0, "Free second", scratch);
    expectCommand(actRead, 1, 0, 0, errFreed, 0, "Read freed", scratch);
    expectCommand(actFree, 1, 0, 0, errFreed, 0, "Free twice", scratch);
    reportTest("access errors", startErrors);
  endtask

  task automatic testArithmetic();
    int     startErrors;
    dataT   model [4];
    dataT   operand;
    dataT   newValue;
    dataT   expected;
    indexT  idx;
    actionE act;
    dataT   scratch;
    startErrors = errorCount;
    expectCommand(actReset, 0, 0, 0, errNone, 0, "Reset", scratch);
    expectCommand(actAlloc, 0, 0, 0, errNone, 12'd0, "Alloc", scratch);
    for (int i = 0; i < 4; i++) begin
      model[i] = dataT'($urandom);
      expectCommand(actWrite, 0, indexT'(i), model[i], errNone, model[i], "Fill", scratch);
    end
    for (int n = 0; n < 40; n++) begin
      idx     = indexT'($urandom % 4);
      operand = dataT'($urandom);
      case ($urandom % 4)
        0:       act = actAdd;
        1:       act = actAddAfter;
        2:       act = actSubtract;
        default: act = actSubAfter;
      endcase
      if (act == actAdd || act == actAddAfter) begin
        newValue = model[idx] + operand;   // 12-bit wrap
      end else begin
        newValue = model[idx] - operand;
      end
      expected   = (act == actAdd || act == actSubtract) ? newValue : model[idx];
      model[idx] = newValue;
      expectCommand(act, 0, idx, operand, errNone, expected, act.name(), scratch);
    end
    reportTest("arithmetic", startErrors);
  endtask

  initial begin
    void'($urandom(32'h6047));
    resetN  = 1'b0;
    request = 1'b0;
    action  = actReset;
    array   = '0;
    index   = '0;
    dataIn  = '0;
    repeat (4) @(posedge clock);
    #10;
    resetN = 1'b1;
    testAllocation();
    testReferenceProgram();
    testPushPop();
    testAccessErrors();
    testArithmetic();
    $display("Checks run: %0d, errors: %0d", checkCount, errorCount);
    if (errorCount == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

//--- dv/heapArrayUnit_chk.sv
//--------------------
// Heap array unit checker
// Request, done and error timing assertions
//--------------------
`timescale 1ns/10ps

module heapArrayUnit_chk (
  input logic           clock,
  input logic           resetN,
  input logic           request,
  input logic           done,
  input heapPkg::errorE error
);
  import heapPkg::*;

  logic completed;   // Some command finished since reset

  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      completed <= 1'b0;
    end else if (done) begin
      completed <= 1'b1;
    end
  end

  doneAfterRequest: assert property (@(posedge clock) disable iff (!resetN)
    request |=> done) else $error("done did not follow a request");

  doneSingleCycle: assert property (@(posedge clock) disable iff (!resetN)
    (done && $past(done)) |-> $past(request)) else $error("done held without a request");

  // Error register stays clear until the first result
  errorQuietAfterReset: assert property (@(posedge clock) disable iff (!resetN)
    (!completed && !done) |-> (error == errNone)) else $error("error set before any command");

endmodule

//--- hdl/arrayAllocator.sv
//--------------------
// Array allocator
// Hands out array numbers, reusing freed ones first
//--------------------
`timescale 1ns/10ps
`include "heap_consts.svh"

module arrayAllocator (
  input  logic           clock,
  input  logic           resetN,
  input  logic           allocate,
  input  logic           releaseArray,
  input  logic           clearAll,
  input  heapPkg::arrayT array,
  output logic           inUse,
  output logic           withinCount,
  output heapPkg::arrayT grantArray,
  output logic           exhausted
);
  import heapPkg::*;

  sizeT                   allocCount;               // Numbers handed out so far
  sizeT                   freedTop;                 // Entries on freed stack
  arrayT                  freedStack [`HEAP_ARRAYS];
  logic [`HEAP_ARRAYS-1:0] allocated;
  sizeT                   topSlot;

  assign topSlot     = freedTop - sizeT'(1);
  assign inUse       = allocated[array];
  assign withinCount = ({1'b0, array} < allocCount);
  assign exhausted   = (freedTop == '0) && (allocCount == sizeT'(`HEAP_ARRAYS));

  // Last freed array goes out first
  assign grantArray = (freedTop != '0) ? freedStack[arrayT'(topSlot)] : arrayT'(allocCount);

  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      allocCount <= '0;
      freedTop   <= '0;
      allocated  <= '0;
    end else if (clearAll) begin
      allocCount <= '0;
      freedTop   <= '0;
      allocated  <= '0;
    end else if (allocate) begin
      if (freedTop != '0) begin
        freedTop <= topSlot;
      end else begin
        allocCount <= allocCount + sizeT'(1);
      end
      allocated[grantArray] <= 1'b1;
    end else if (releaseArray) begin
      freedTop         <= freedTop + sizeT'(1);
      allocated[array] <= 1'b0;   // Flag of the freed array itself
    end
  end

  // Freed array numbers pushed on Free
  always_ff @(posedge clock) begin
    if (releaseArray && !clearAll) begin
      freedStack[arrayT'(freedTop)] <= array;
    end
  end

endmodule

//--- hdl/arrayStore.sv
//--------------------
// Array store
// Element memory with write and add or subtract update
//--------------------
`timescale 1ns/10ps
`include "heap_consts.svh"

module arrayStore (
  input  logic             clock,
  input  logic             resetN,
  input  heapPkg::arrayT   array,
  input  heapPkg::indexT   elementIndex,
  input  heapPkg::storeOpE storeOp,
  input  heapPkg::dataT    dataIn,
  output heapPkg::dataT    elementOld,
  output heapPkg::dataT    elementNew
);
  import heapPkg::*;

  dataT memory [`HEAP_ARRAYS][`HEAP_LENGTH];   // Fixed block per array

  assign elementOld = memory[array][elementIndex];

  // Value the element takes if the update is enabled
  always_comb begin
    case (storeOp)
      storeWrite:    elementNew = dataIn;
      storeAdd:      elementNew = elementOld + dataIn;   // Wraps at 12 bits
      storeSubtract: elementNew = elementOld - dataIn;
      default:       elementNew = elementOld;
    endcase
  end

  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      for (int a = 0; a < `HEAP_ARRAYS; a++) begin
        for (int e = 0; e < `HEAP_LENGTH; e++) begin
          memory[a][e] <= '0;
        end
      end
    end else if (storeOp != storeNone) begin
      memory[array][elementIndex] <= elementNew;
    end
  end

endmodule

//--- hdl/heapArrayUnit.sv
//--------------------
// Heap array unit
// Command control around element store, size table and allocator
//--------------------
`timescale 1ns/10ps

module heapArrayUnit (
  input  logic            clock,
  input  logic            resetN,
  input  logic            request,   // One-cycle command strobe
  input  heapPkg::actionE action,
  input  heapPkg::arrayT  array,
  input  heapPkg::indexT  index,
  input  heapPkg::dataT   dataIn,
  output heapPkg::dataT   dataOut,
  output heapPkg::errorE  error,
  output logic            done       // One cycle after request
);
  import heapPkg::*;

  indexT   elementIndex;
  storeOpE storeOp;
  sizeOpE  sizeOp;
  logic    allocate;
  logic    releaseArray;
  logic    clearAll;
  dataT    elementOld;
  dataT    elementNew;
  sizeT    size;
  logic    full;
  logic    empty;
  logic    inUse;
  logic    withinCount;
  arrayT   grantArray;
  logic    exhausted;
  arrayT   sizeArray;

  // Alloc clears the size of the granted array
  assign sizeArray = allocate ? grantArray : array;

  heapControl u_control (
    .clock        (clock),
    .resetN       (resetN),
    .request      (request),
    .action       (action),
    .array        (array),
    .index        (index),
    .dataIn       (dataIn),
    .elementOld   (elementOld),
    .elementNew   (elementNew),
    .size         (size),
    .full         (full),
    .empty        (empty),
    .inUse        (inUse),
    .withinCount  (withinCount),
    .grantArray   (grantArray),
    .exhausted    (exhausted),
    .elementIndex (elementIndex),
    .storeOp      (storeOp),
    .sizeOp       (sizeOp),
    .allocate     (allocate),
    .releaseArray (releaseArray),
    .clearAll     (clearAll),
    .dataOut      (dataOut),
    .error        (error),
    .done         (done)
  );

  arrayStore u_store (
    .clock        (clock),
    .resetN       (resetN),
    .array        (array),
    .elementIndex (elementIndex),
    .storeOp      (storeOp),
    .dataIn       (dataIn),
    .elementOld   (elementOld),
    .elementNew   (elementNew)
  );

  sizeTable u_sizes (
    .clock  (clock),
    .resetN (resetN),
    .array  (sizeArray),
    .index  (index),
    .sizeOp (sizeOp),
    .size   (size),
    .full   (full),
    .empty  (empty)
  );

  arrayAllocator u_alloc (
    .clock        (clock),
    .resetN       (resetN),
    .allocate     (allocate),
    .releaseArray (releaseArray),
    .clearAll     (clearAll),
    .array        (array),
    .inUse        (inUse),
    .withinCount  (withinCount),
    .grantArray   (grantArray),
    .exhausted    (exhausted)
  );

endmodule

//--- hdl/heapControl.sv
//--------------------
// Heap control
// Decodes a command, checks access and registers the result
//--------------------
`timescale 1ns/10ps
`include "heap_consts.svh"

module heapControl (
  input  logic             clock,
  input  logic             resetN,
  input  logic             request,
  input  heapPkg::actionE  action,
  input  heapPkg::arrayT   array,
  input  heapPkg::indexT   index,
  input  heapPkg::dataT    dataIn,
  input  heapPkg::dataT    elementOld,
  input  heapPkg::dataT    elementNew,
  input  heapPkg::sizeT    size,
  input  logic             full,
  input  logic             empty,
  input  logic             inUse,
  input  logic             withinCount,
  input  heapPkg::arrayT   grantArray,
  input  logic             exhausted,
  output heapPkg::indexT   elementIndex,
  output heapPkg::storeOpE storeOp,
  output heapPkg::sizeOpE  sizeOp,
  output logic             allocate,
  output logic             releaseArray,
  output logic             clearAll,
  output heapPkg::dataT    dataOut,
  output heapPkg::errorE   error,
  output logic             done
);
  import heapPkg::*;

  logic  arrayAction;   // Needs an allocated array
  logic  bounded;       // Needs index below size
  logic  commit;
  sizeT  popSize;
  errorE cmdError;
  dataT  cmdData;

  assign arrayAction = action inside {actWrite, actRead, actSize, actPush, actPop, actFree,
                                      actAdd, actAddAfter, actSubtract, actSubAfter};
  assign bounded     = action inside {actRead, actAdd, actAddAfter, actSubtract, actSubAfter};
  assign popSize     = size - sizeT'(1);
  assign commit      = request && (cmdError == errNone);

  // Alloc and Reset depend on allocator state only
  assign allocate     = request && (action == actAlloc) && !exhausted;
  assign clearAll     = request && (action == actReset);
  assign releaseArray = commit && (action == actFree);

  //--------------------
  // Access checks
  //--------------------
  always_comb begin
    cmdError = errNone;
    if (arrayAction && !withinCount) begin
      cmdError = errNotAllocated;
    end else if (arrayAction && !inUse) begin
      cmdError = errFreed;
    end else if (bounded && ({1'b0, index} >= size)) begin
      cmdError = errOutOfBounds;
    end else if ((action == actPush) && full) begin
      cmdError = errFull;
    end else if ((action == actPop) && empty) begin
      cmdError = errEmpty;
    end else if ((action == actAlloc) && exhausted) begin
      cmdError = errOutOfMemory;
    end
  end

  // Push writes at the top, Pop reads the last element
  always_comb begin
    case (action)
      actPush: elementIndex = size[`HEAP_INDEX_BITS-1:0];
      actPop:  elementIndex = popSize[`HEAP_INDEX_BITS-1:0];
      default: elementIndex = index;
    endcase
  end

  //--------------------
  // Datapath enables
  //--------------------
  always_comb begin
    storeOp = storeNone;
    sizeOp  = sizeHold;
    if (commit) begin
      case (action)
        actReset:                 sizeOp = sizeClearAll;
        actWrite: begin
          storeOp = storeWrite;
          sizeOp  = sizeGrow;                    // Grows only past the end
        end
        actPush: begin
          storeOp = storeWrite;
          sizeOp  = sizePush;
        end
        actPop:                   sizeOp  = sizePop;
        actAlloc:                 sizeOp  = sizeClear;
        actAdd, actAddAfter:      storeOp = storeAdd;
        actSubtract, actSubAfter: storeOp = storeSubtract;
        default: ;
      endcase
    end
  end

  // Result data of a successful command
  always_comb begin
    case (action)
      actWrite, actPush:        cmdData = dataIn;
      actRead, actPop:          cmdData = elementOld;
      actSize:                  cmdData = dataT'(size);
      actAlloc:                 cmdData = dataT'(grantArray);
      actAdd, actSubtract:      cmdData = elementNew;
      actAddAfter, actSubAfter: cmdData = elementOld;
      default:                  cmdData = dataOut;   // Reset, Free, no-op
    endcase
  end

  //--------------------
  // Result registers
  //--------------------
  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      dataOut <= '0;
      error   <= errNone;
      done    <= 1'b0;
    end else begin
      done <= request;
      if (request) begin
        error <= cmdError;
      end
      if (commit) begin
        dataOut <= cmdData;   // Failures keep the old value
      end
    end
  end

endmodule

//--- hdl/heapPkg.sv
//--------------------
// Heap package
// Field types and command, error and operation codes
//--------------------
`include "heap_consts.svh"

package heapPkg;

  typedef logic [`HEAP_ARRAY_BITS-1:0] arrayT;  // Array number
  typedef logic [`HEAP_INDEX_BITS-1:0] indexT;  // Element index
  typedef logic [`HEAP_INDEX_BITS:0]   sizeT;   // Size 0 to length
  typedef logic [`HEAP_DATA_BITS-1:0]  dataT;   // Element data

  // Command codes, unlisted values do nothing
  typedef enum logic [4:0] {
    actReset    = 5'd1,
    actWrite    = 5'd2,
    actRead     = 5'd3,
    actSize     = 5'd4,
    actPush     = 5'd14,
    actPop      = 5'd15,
    actAlloc    = 5'd18,
    actFree     = 5'd19,
    actAdd      = 5'd20,   // Returns new value
    actAddAfter = 5'd21,   // Returns old value
    actSubtract = 5'd22,   // Returns new value
    actSubAfter = 5'd23    // Returns old value
  } actionE;

  typedef enum logic [2:0] {
    errNone, errNotAllocated, errFreed, errOutOfBounds, errFull, errEmpty, errOutOfMemory
  } errorE;

  // Size table update
  typedef enum logic [2:0] {
    sizeHold, sizeClear, sizeGrow, sizePush, sizePop, sizeClearAll
  } sizeOpE;

  // Element store update
  typedef enum logic [1:0] {
    storeNone, storeWrite, storeAdd, storeSubtract
  } storeOpE;

endpackage

//--- hdl/heap_consts.svh
//--------------------
// Heap constants
// Widths and counts shared by the array heap
//--------------------
`ifndef HEAP_CONSTS_SVH
`define HEAP_CONSTS_SVH

// Field widths
`define HEAP_ARRAY_BITS 2   // Bits of an array number
`define HEAP_INDEX_BITS 2   // Bits of an element index
`define HEAP_DATA_BITS  12  // Bits of one element

//--------------------
// Heap geometry
//--------------------
`define HEAP_ARRAYS 4   // Arrays in the heap
`define HEAP_LENGTH 4   // Elements per array

`endif

//--- hdl/sizeTable.sv
//--------------------
// Size table
// Current size of each array with full and empty flags
//--------------------
`timescale 1ns/10ps
`include "heap_consts.svh"

module sizeTable (
  input  logic            clock,
  input  logic            resetN,
  input  heapPkg::arrayT  array,
  input  heapPkg::indexT  index,
  input  heapPkg::sizeOpE sizeOp,
  output heapPkg::sizeT   size,
  output logic            full,
  output logic            empty
);
  import heapPkg::*;

  sizeT sizes [`HEAP_ARRAYS];
  sizeT reach;   // Size needed to cover index

  assign size  = sizes[array];
  assign full  = (size == sizeT'(`HEAP_LENGTH));
  assign empty = (size == '0);
  assign reach = sizeT'(index) + sizeT'(1);

  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      for (int a = 0; a < `HEAP_ARRAYS; a++) begin
        sizes[a] <= '0;
      end
    end else begin
      case (sizeOp)
        sizeClearAll: begin
          for (int a = 0; a < `HEAP_ARRAYS; a++) begin
            sizes[a] <= '0;
          end
        end
        sizeClear: sizes[array] <= '0;   // Fresh array from Alloc
        sizeGrow: begin
          if (reach > size) begin
            sizes[array] <= reach;
          end
        end
        sizePush: sizes[array] <= size + sizeT'(1);
        sizePop:  sizes[array] <= size - sizeT'(1);
        default: ;
      endcase
    end
  end

endmodule
